// File: spike_linear.f
verilog/spike_linear_pkg.sv
verilog/row_if.sv
verilog/spike_row_feeder.sv
verilog/spike_accumulator.sv
verilog/psum_drain.sv
verilog/spike_linear.sv
testbench/spike_linear_sva.sv
testbench/spike_linear_tb.sv

// File: testbench/spike_linear_tb.sv
`default_nettype none

module spike_linear_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int DIM_IN     = 8;
    localparam int DIM_OUT    = 4;
    localparam int T_STEPS    = spike_linear_pkg::T_STEPS;
    localparam int PSUM_W     = spike_linear_pkg::PSUM_W;
    localparam int SPK_W      = DIM_IN * T_STEPS;
    localparam int WORD_W     = T_STEPS * PSUM_W;
    localparam int WAIT_LIMIT = 500;   // Cycles per wait loop

    logic                           s_clk;
    logic                           i_reset;
    logic                           i_wt_valid;
    spike_linear_pkg::weight_t      i_wt_data;
    logic                           o_wt_ready;
    logic                           o_wt_loaded;
    logic                           i_spk_valid;
    logic [SPK_W-1:0]               i_spk_data;
    logic                           o_spk_ready;
    logic                           o_psum_valid;
    logic [WORD_W-1:0]              o_psum_data;
    logic                           o_psum_last;
    logic                           i_psum_ready;

    integer                         seed = 39167;
    spike_linear_pkg::weight_t      wt_model [DIM_IN][DIM_OUT];
    logic [WORD_W-1:0]              exp_q [$];     // Expected words, oldest first
    int                             errors = 0;
    int                             words_seen = 0;
    int                             test_num = 0;
    int                             tests_passed = 0;
    int                             test_errs;
    bit                             stall_mode = 1'b0;

    spike_linear #(
        .DIM_IN         (DIM_IN),
        .DIM_OUT        (DIM_OUT)
    ) i_spike_linear (
        .s_clk          (s_clk),
        .i_reset        (i_reset),
        .i_wt_valid     (i_wt_valid),
        .i_wt_data      (i_wt_data),
        .o_wt_ready     (o_wt_ready),
        .o_wt_loaded    (o_wt_loaded),
        .i_spk_valid    (i_spk_valid),
        .i_spk_data     (i_spk_data),
        .o_spk_ready    (o_spk_ready),
        .o_psum_valid   (o_psum_valid),
        .o_psum_data    (o_psum_data),
        .o_psum_last    (o_psum_last),
        .i_psum_ready   (i_psum_ready)
    );

    initial s_clk = 1'b0;
    always #10 s_clk = ~s_clk;

    function automatic int error_total();
        return errors + i_spike_linear.u_sva.fail_count;
    endfunction

    task automatic check_bit(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            $display("[FAIL] %s: expected %h, got %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic abort_wait(input string what);
        $display("Timeout while waiting for %s", what);
        $display("Test failed");
        $finish;
    endtask

    task automatic report_test(input string name);
        test_num++;
        if (error_total() == test_errs) begin
            tests_passed++;
            $display("test %0d %s: pass", test_num, name);
        end else begin
            $display("test %0d %s: %0d errors", test_num, name, error_total() - test_errs);
        end
    endtask

    // Each lane t of channel j sums the weights of inputs that spiked in step t
    task automatic push_expected(input logic [SPK_W-1:0] tok);
        int                 sum;
        logic [WORD_W-1:0]  word;
        for (int j = 0; j < DIM_OUT; j++) begin
            word = '0;
            for (int t = 0; t < T_STEPS; t++) begin
                sum = 0;
                for (int i = 0; i < DIM_IN; i++) begin
                    if (tok[i*T_STEPS + t]) begin
                        sum += int'(wt_model[i][j]);
                    end
                end
                word[t*PSUM_W +: PSUM_W] = sum[PSUM_W-1:0];
            end
            exp_q.push_back(word);
        end
    endtask

    task automatic load_weights();
        int waited;
        for (int i = 0; i < DIM_IN; i++) begin
            for (int j = 0; j < DIM_OUT; j++) begin
                wt_model[i][j] = spike_linear_pkg::weight_t'($random(seed));
                @(negedge s_clk);
                i_wt_valid = 1'b1;
                i_wt_data  = wt_model[i][j];
                #1;
                waited = 0;
                while (!o_wt_ready) begin
                    if (waited == WAIT_LIMIT) abort_wait("o_wt_ready during weight load");
                    @(negedge s_clk);
                    #1;
                    waited++;
                end
            end
        end
        @(negedge s_clk);
        i_wt_valid = 1'b0;
        #1;
        waited = 0;
        while (!o_wt_loaded) begin
            if (waited == WAIT_LIMIT) abort_wait("o_wt_loaded after weight load");
            @(negedge s_clk);
            #1;
            waited++;
        end
    endtask

    // Transfer happens on the rising edge after ready is seen
    task automatic send_token(input logic [SPK_W-1:0] tok);
        int waited;
        push_expected(tok);
        @(negedge s_clk);
        i_spk_valid = 1'b1;
        i_spk_data  = tok;
        #1;
        waited = 0;
        while (!o_spk_ready) begin
            if (waited == WAIT_LIMIT) abort_wait("o_spk_ready to accept a token");
            @(negedge s_clk);
            #1;
            waited++;
        end
    endtask

    task automatic idle_spikes();
        @(negedge s_clk);
        i_spk_valid = 1'b0;
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            if (waited == WAIT_LIMIT) abort_wait("all expected psum words");
            @(negedge s_clk);
            #2;
            waited++;
        end
        // Nothing may follow the last expected word
        @(negedge s_clk);
        #2;
        check_bit("o_psum_valid", o_psum_valid, 1'b0);
    endtask

    // Psum sink, compares each accepted word with the model
    always @(negedge s_clk) begin
        logic [WORD_W-1:0]  exp_word;
        logic               exp_last;
        i_psum_ready = stall_mode ? 1'($random(seed)) : 1'b1;
        #1;
        if (!i_reset && o_psum_valid && i_psum_ready) begin
            exp_last = (words_seen % DIM_OUT) == (DIM_OUT - 1);
            if (exp_q.size() == 0) begin
                $display("Psum word arrived with no token outstanding");
                errors++;
            end else begin
                exp_word = exp_q.pop_front();
                assert (o_psum_data === exp_word) else begin
                    $display("[FAIL] o_psum_data: expected %h, got %h", exp_word, o_psum_data);
                    errors++;
                end
                check_bit("o_psum_last", o_psum_last, exp_last);
            end
            words_seen++;
        end
    end

    initial begin
        i_reset      = 1'b1;
        i_wt_valid   = 1'b0;
        i_wt_data    = '0;
        i_spk_valid  = 1'b0;
        i_spk_data   = '0;
        i_psum_ready = 1'b1;
        repeat (2) @(negedge s_clk);
        i_reset = 1'b0;

        test_errs = error_total();
        #1;
        check_bit("o_wt_ready", o_wt_ready, 1'b1);
        check_bit("o_wt_loaded", o_wt_loaded, 1'b0);
        check_bit("o_spk_ready", o_spk_ready, 1'b0);
        check_bit("o_psum_valid", o_psum_valid, 1'b0);
        report_test("reset state");

        test_errs = error_total();
        load_weights();
        check_bit("o_wt_ready", o_wt_ready, 1'b0);
        check_bit("o_spk_ready", o_spk_ready, 1'b1);
        report_test("weight load");

        test_errs = error_total();
        send_token('1);     // Every lane gets its full column sum
        idle_spikes();
        wait_drained();
        report_test("all-spikes token");

        test_errs = error_total();
        for (int k = 0; k < 8; k++) begin
            send_token(SPK_W'($random(seed)));
        end
        idle_spikes();
        wait_drained();
        report_test("random tokens");

        test_errs = error_total();
        stall_mode = 1'b1;
        for (int k = 0; k < 6; k++) begin
            send_token(SPK_W'($random(seed)));
        end
        idle_spikes();
        wait_drained();
        stall_mode = 1'b0;
        report_test("back-pressure");

        $display("tests run %0d, passed %0d, errors %0d", test_num, tests_passed, error_total());
        if (error_total() == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/spike_linear_sva.sv
`default_nettype none

module spike_linear_sva (
    input wire                                      s_clk,
    input wire                                      i_reset,
    input wire                                      o_wt_ready,
    input wire                                      o_wt_loaded,
    input wire                                      o_psum_valid,
    input wire [spike_linear_pkg::T_STEPS*spike_linear_pkg::PSUM_W-1:0] o_psum_data,
    input wire                                      o_psum_last,
    input wire                                      i_psum_ready
);

    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;     // Read by the testbench at the end

    // A stalled word must not move
    a_psum_hold: assert property (@(posedge s_clk) disable iff (i_reset)
        (o_psum_valid && !i_psum_ready) |=>
            (o_psum_valid && $stable(o_psum_data) && $stable(o_psum_last)))
    else begin
        $error("psum word changed while stalled");
        fail_count++;
    end

    a_wt_flags: assert property (@(posedge s_clk) disable iff (i_reset)
        !(o_wt_ready && o_wt_loaded))
    else begin
        $error("o_wt_ready and o_wt_loaded high together");
        fail_count++;
    end

    a_last_valid: assert property (@(posedge s_clk) disable iff (i_reset)
        o_psum_last |-> o_psum_valid)
    else begin
        $error("o_psum_last without o_psum_valid");
        fail_count++;
    end

endmodule

bind spike_linear spike_linear_sva u_sva (
    .s_clk          (s_clk),
    .i_reset        (i_reset),
    .o_wt_ready     (o_wt_ready),
    .o_wt_loaded    (o_wt_loaded),
    .o_psum_valid   (o_psum_valid),
    .o_psum_data    (o_psum_data),
    .o_psum_last    (o_psum_last),
    .i_psum_ready   (i_psum_ready)
);

`default_nettype wire

// File: verilog/spike_linear.sv
`default_nettype none

module spike_linear #(
    parameter int DIM_IN  = 8,
    parameter int DIM_OUT = 4
) (
    input  wire                                     s_clk,
    input  wire                                     i_reset,

    input  wire                                     i_wt_valid,
    input  spike_linear_pkg::weight_t               i_wt_data,
    output logic                                    o_wt_ready,
    output logic                                    o_wt_loaded,

    input  wire                                     i_spk_valid,
    input  wire [DIM_IN*spike_linear_pkg::T_STEPS-1:0] i_spk_data,
    output logic                                    o_spk_ready,

    output logic                                    o_psum_valid,
    output logic [spike_linear_pkg::T_STEPS*spike_linear_pkg::PSUM_W-1:0] o_psum_data,
    output logic                                    o_psum_last,
    input  wire                                     i_psum_ready
);

    logic                                           res_valid;
    logic                                           res_ready;
    spike_linear_pkg::psum_word_u [DIM_OUT-1:0]     res_data;

    row_if #(.DIM_OUT(DIM_OUT)) u_row ();

    spike_row_feeder #(
        .DIM_IN         (DIM_IN),
        .DIM_OUT        (DIM_OUT)
    ) u_feeder (
        .s_clk          (s_clk),
        .i_reset        (i_reset),
        .i_wt_valid     (i_wt_valid),
        .i_wt_data      (i_wt_data),
        .o_wt_ready     (o_wt_ready),
        .o_wt_loaded    (o_wt_loaded),
        .i_spk_valid    (i_spk_valid),
        .i_spk_data     (i_spk_data),
        .o_spk_ready    (o_spk_ready),
        .row            (u_row.feeder)
    );

    spike_accumulator #(
        .DIM_IN         (DIM_IN),
        .DIM_OUT        (DIM_OUT)
    ) u_accumulator (
        .s_clk          (s_clk),
        .i_reset        (i_reset),
        .row            (u_row.acc),
        .o_res_valid    (res_valid),
        .o_res_data     (res_data),
        .i_res_ready    (res_ready)
    );

    // Second token can accumulate while this one drains
    psum_drain #(
        .DIM_OUT        (DIM_OUT)
    ) u_drain (
        .s_clk          (s_clk),
        .i_reset        (i_reset),
        .i_res_valid    (res_valid),
        .i_res_data     (res_data),
        .o_res_ready    (res_ready),
        .o_psum_valid   (o_psum_valid),
        .o_psum_data    (o_psum_data),
        .o_psum_last    (o_psum_last),
        .i_psum_ready   (i_psum_ready)
    );

endmodule

`default_nettype wire

// File: verilog/psum_drain.sv
`default_nettype none

module psum_drain #(
    parameter int DIM_OUT = 4
) (
    input  wire                                         s_clk,
    input  wire                                         i_reset,

    input  wire                                         i_res_valid,
    input  spike_linear_pkg::psum_word_u [DIM_OUT-1:0]  i_res_data,
    output logic                                        o_res_ready,

    output logic                                        o_psum_valid,
    output logic [spike_linear_pkg::T_STEPS*spike_linear_pkg::PSUM_W-1:0] o_psum_data,
    output logic                                        o_psum_last,
    input  wire                                         i_psum_ready
);

    localparam int IDX_W = (DIM_OUT > 1) ? $clog2(DIM_OUT) : 1;
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(DIM_OUT - 1);

    spike_linear_pkg::psum_word_u [DIM_OUT-1:0]         res_buf;
    logic                                               full;
    logic [IDX_W-1:0]                                   out_idx;

    assign o_res_ready  = ~full;
    assign o_psum_valid = full;
    assign o_psum_data  = res_buf[out_idx].flat;
    assign o_psum_last  = full & (out_idx == LAST_IDX);

    always_ff @(posedge s_clk) begin
        if (i_res_valid && o_res_ready) begin
            res_buf <= i_res_data;
        end
    end

    always_ff @(posedge s_clk) begin
        if (i_reset) begin
            full    <= 1'b0;
            out_idx <= '0;
        end else if (i_res_valid && o_res_ready) begin
            full    <= 1'b1;
            out_idx <= '0;
        end else if (o_psum_valid && i_psum_ready) begin
            if (o_psum_last) begin
                full <= 1'b0;
            end else begin
                out_idx <= out_idx + 1'b1;  // Holds while the sink stalls
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/spike_accumulator.sv
`default_nettype none

module spike_accumulator #(
    parameter int DIM_IN  = 8,
    parameter int DIM_OUT = 4
) (
    input  wire                                         s_clk,
    input  wire                                         i_reset,

    row_if.acc                                          row,

    output logic                                        o_res_valid,
    output spike_linear_pkg::psum_word_u [DIM_OUT-1:0]  o_res_data,
    input  wire                                         i_res_ready
);

    spike_linear_pkg::psum_word_u [DIM_OUT-1:0]         acc_q;
    logic                                               pending;

    assign row.ready   = ~pending;      // Stall rows while a result waits
    assign o_res_valid = pending;
    assign o_res_data  = acc_q;

    always_ff @(posedge s_clk) begin
        if (i_reset) begin
            acc_q   <= '0;
            pending <= 1'b0;
        end else if (o_res_valid && i_res_ready) begin
            acc_q   <= '0;              // Next token starts from zero
            pending <= 1'b0;
        end else if (row.valid && row.ready) begin
            for (int j = 0; j < DIM_OUT; j++) begin
                for (int t = 0; t < spike_linear_pkg::T_STEPS; t++) begin
                    if (row.spikes[t]) begin
                        acc_q[j].lanes[t] <= acc_q[j].lanes[t]
                            + spike_linear_pkg::psum_lane_t'(row.weights[j]);
                    end
                end
            end
            if (row.last) begin
                pending <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/spike_row_feeder.sv
`default_nettype none

module spike_row_feeder #(
    parameter int DIM_IN  = 8,
    parameter int DIM_OUT = 4
) (
    input  wire                                     s_clk,
    input  wire                                     i_reset,

    input  wire                                     i_wt_valid,
    input  spike_linear_pkg::weight_t               i_wt_data,
    output logic                                    o_wt_ready,
    output logic                                    o_wt_loaded,

    input  wire                                     i_spk_valid,
    input  wire [DIM_IN*spike_linear_pkg::T_STEPS-1:0] i_spk_data,
    output logic                                    o_spk_ready,

    row_if.feeder                                   row
);

    localparam int ROW_W = (DIM_IN > 1) ? $clog2(DIM_IN) : 1;
    localparam int COL_W = (DIM_OUT > 1) ? $clog2(DIM_OUT) : 1;
    localparam logic [ROW_W-1:0] LAST_ROW = ROW_W'(DIM_IN - 1);
    localparam logic [COL_W-1:0] LAST_COL = COL_W'(DIM_OUT - 1);

    spike_linear_pkg::weight_t [DIM_OUT-1:0]        wt_mem [DIM_IN];
    logic [ROW_W-1:0]                               wt_row;
    logic [COL_W-1:0]                               wt_col;
    logic                                           loaded;

    logic [DIM_IN*spike_linear_pkg::T_STEPS-1:0]    spk_buf;
    logic                                           held;
    logic [ROW_W-1:0]                               row_idx;

    assign o_wt_ready  = ~loaded;       // One load per reset
    assign o_wt_loaded = loaded;
    assign o_spk_ready = loaded & ~held;

    // Weight store, beats arrive in input-row order
    always_ff @(posedge s_clk) begin
        if (i_wt_valid && o_wt_ready) begin
            wt_mem[wt_row][wt_col] <= i_wt_data;
        end
    end

    always_ff @(posedge s_clk) begin
        if (i_reset) begin
            wt_row <= '0;
            wt_col <= '0;
            loaded <= 1'b0;
        end else if (i_wt_valid && o_wt_ready) begin
            if (wt_col == LAST_COL) begin
                wt_col <= '0;
                if (wt_row == LAST_ROW) begin
                    loaded <= 1'b1;
                end else begin
                    wt_row <= wt_row + 1'b1;
                end
            end else begin
                wt_col <= wt_col + 1'b1;
            end
        end
    end

    always_ff @(posedge s_clk) begin
        if (i_spk_valid && o_spk_ready) begin
            spk_buf <= i_spk_data;
        end
    end

    // Token walk, one row per accepted transfer
    always_ff @(posedge s_clk) begin
        if (i_reset) begin
            held    <= 1'b0;
            row_idx <= '0;
        end else if (i_spk_valid && o_spk_ready) begin
            held    <= 1'b1;
            row_idx <= '0;
        end else if (row.valid && row.ready) begin
            if (row.last) begin
                held <= 1'b0;                   // Free for the next token
            end else begin
                row_idx <= row_idx + 1'b1;
            end
        end
    end

    assign row.valid   = held;
    assign row.spikes  = spk_buf[row_idx*spike_linear_pkg::T_STEPS +: spike_linear_pkg::T_STEPS];
    assign row.weights = wt_mem[row_idx];
    assign row.last    = (row_idx == LAST_ROW);

endmodule

`default_nettype wire

// File: verilog/row_if.sv
`default_nettype none

// One input-channel row: its spikes and the matching weight row
interface row_if #(
    parameter int DIM_OUT = 4
) ();

    logic                                           valid;
    logic                                           ready;
    spike_linear_pkg::spikes_t                      spikes;
    spike_linear_pkg::weight_t [DIM_OUT-1:0]        weights;
    logic                                           last;   // Row DIM_IN-1

    modport feeder (
        output valid,
        output spikes,
        output weights,
        output last,
        input  ready
    );

    modport acc (
        input  valid,
        input  spikes,
        input  weights,
        input  last,
        output ready
    );

endinterface

`default_nettype wire

// File: verilog/spike_linear_pkg.sv
`default_nettype none

package spike_linear_pkg;

    localparam int T_STEPS  = 4;    // Spike time steps per token
    localparam int WEIGHT_W = 8;
    localparam int PSUM_W   = 20;

    typedef logic signed [WEIGHT_W-1:0] weight_t;

    typedef logic signed [PSUM_W-1:0] psum_lane_t;

    // One input channel, bit t is the spike of step t
    typedef logic [T_STEPS-1:0] spikes_t;

    // Output word, seen as one vector or as per-step lanes (lane 0 low)
    typedef union packed {
        logic [T_STEPS*PSUM_W-1:0]        flat;
        psum_lane_t [T_STEPS-1:0]         lanes;
    } psum_word_u;

endpackage

`default_nettype wire
